// File: hw/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

	// ==============================
	// instruction fields
	// ==============================
	localparam int OPCODE_MSB = 31;
	localparam int OPCODE_LSB = 26;
	localparam int FUNCT_MSB  = 5;
	localparam int FUNCT_LSB  = 0;
	localparam int IMM_MSB    = 15;
	localparam int IMM_LSB    = 0;

	// ==============================
	// encodings
	// ==============================
	typedef enum logic [5:0] {
		op_r_type = 6'b00_0000,
		op_beq    = 6'b00_0100,
		op_lw     = 6'b10_0011,
		op_sw     = 6'b10_1011
	} opcode_e;

	typedef enum logic [5:0] {
		funct_jr  = 6'b00_1000, // jump register, alu result ignored.
		funct_add = 6'b10_0000,
		funct_sub = 6'b10_0010,
		funct_and = 6'b10_0100,
		funct_or  = 6'b10_0101,
		funct_slt = 6'b10_1010
	} funct_e;

	// class handed from the main decoder to the alu control decoder.
	typedef enum logic [1:0] {
		alu_op_mem     = 2'b00,
		alu_op_beq     = 2'b01,
		alu_op_arith   = 2'b10,
		alu_op_illegal = 2'b11
	} alu_op_e;

endpackage

`default_nettype wire

// File: hw/alu_pkg.sv
`default_nettype none

package alu_pkg;

	localparam int DATA_WIDTH  = 32;
	localparam int SLICE_WIDTH = 4;
	localparam int NUM_SLICES  = DATA_WIDTH / SLICE_WIDTH;

	// ==============================
	// alu control codes
	// ==============================
	typedef enum logic [3:0] {
		and_op = 4'b0000,
		or_op  = 4'b0001,
		add_op = 4'b0010,
		sub_op = 4'b0110, // b inverted, carry in set.
		slt_op = 4'b0111  // subtract, then keep the sign.
	} alu_ctrl_e;

endpackage

`default_nettype wire

// File: hw/main_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module main_decoder
	import mips_isa_pkg::*;
(
	input  wire logic [5:0] opcode,
	output alu_op_e         alu_op,
	output logic            imm_select
);

	always_comb begin
		alu_op     = alu_op_illegal;
		imm_select = 1'b0;
		case (opcode)
			op_lw, op_sw: begin
				alu_op     = alu_op_mem; // base plus offset.
				imm_select = 1'b1;
			end
			op_beq: begin
				alu_op     = alu_op_beq; // compare by subtracting.
				imm_select = 1'b0;
			end
			op_r_type: begin
				alu_op     = alu_op_arith;
				imm_select = 1'b0;
			end
			default: begin
				alu_op     = alu_op_illegal;
				imm_select = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/alu_control.sv
`timescale 1ns/1ps
`default_nettype none

module alu_control
	import mips_isa_pkg::*;
	import alu_pkg::*;
(
	input  wire alu_op_e    alu_op,
	input  wire logic [5:0] funct,
	output alu_ctrl_e       alu_ctrl,
	output logic            err_illegal_funct,
	output logic            err_illegal_op
);

	alu_ctrl_e funct_ctrl;
	logic      funct_unknown;

	// ==============================
	// function field decode
	// ==============================
	always_comb begin
		funct_ctrl    = and_op;
		funct_unknown = 1'b0;
		case (funct)
			funct_add: funct_ctrl = add_op;
			funct_sub: funct_ctrl = sub_op;
			funct_and: funct_ctrl = and_op;
			funct_or:  funct_ctrl = or_op;
			funct_slt: funct_ctrl = slt_op;
			funct_jr:  funct_ctrl = and_op; // alu output unused, and is cheapest.
			default: begin
				funct_ctrl    = and_op;
				funct_unknown = 1'b1;
			end
		endcase
	end

	// ==============================
	// class select
	// ==============================
	always_comb begin
		alu_ctrl          = and_op;
		err_illegal_funct = 1'b0;
		err_illegal_op    = 1'b0;
		case (alu_op)
			alu_op_mem: alu_ctrl = add_op;
			alu_op_beq: alu_ctrl = sub_op;
			alu_op_arith: begin
				alu_ctrl          = funct_ctrl;
				err_illegal_funct = funct_unknown; // i-type immediates never flag.
			end
			default: begin
				alu_ctrl       = and_op;
				err_illegal_op = 1'b1;
			end
		endcase
	end

	always_comb begin
		assert final (!(err_illegal_funct || err_illegal_op) || alu_ctrl == and_op)
			else $error("alu_control: error flag raised with control %0h", alu_ctrl);
		assert final (!(err_illegal_funct && err_illegal_op))
			else $error("alu_control: both error flags high");
	end

endmodule

`default_nettype wire

// File: hw/alu_slice.sv
`timescale 1ns/1ps
`default_nettype none

module alu_slice
	import alu_pkg::*;
#(
	parameter bit FIRST_SLICE = 1'b0
) (
	input  wire alu_ctrl_e              alu_ctrl,
	input  wire logic [SLICE_WIDTH-1:0] a,
	input  wire logic [SLICE_WIDTH-1:0] b,
	input  wire logic                   carry_in,
	output logic      [SLICE_WIDTH-1:0] result,
	output logic                        carry_out
);

	logic                   sub_mode;
	logic [SLICE_WIDTH-1:0] b_eff;
	logic [SLICE_WIDTH-1:0] g;
	logic [SLICE_WIDTH-1:0] p;
	logic [SLICE_WIDTH-1:0] sum;
	logic [SLICE_WIDTH:0]   c;

	assign sub_mode = (alu_ctrl == sub_op) || (alu_ctrl == slt_op);
	assign b_eff    = sub_mode ? ~b : b;
	assign g        = a & b_eff;
	assign p        = a ^ b_eff;

	// lowest slice supplies the +1 of the two's complement itself.
	assign c[0] = FIRST_SLICE ? sub_mode : carry_in;

	// lookahead carries.
	assign c[1] = g[0] | (p[0] & c[0]);
	assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c[0]);
	assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) |
		(p[2] & p[1] & p[0] & c[0]);
	assign c[4] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) |
		(p[3] & p[2] & p[1] & g[0]) | (p[3] & p[2] & p[1] & p[0] & c[0]);

	assign sum       = p ^ c[SLICE_WIDTH-1:0];
	assign carry_out = c[SLICE_WIDTH];

	always_comb begin
		case (alu_ctrl)
			and_op:  result = a & b;
			or_op:   result = a | b;
			default: result = sum; // add, sub and slt.
		endcase
	end

endmodule

`default_nettype wire

// File: hw/alu_result_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_result_unit
	import alu_pkg::*;
(
	input  wire alu_ctrl_e             alu_ctrl,
	input  wire logic [DATA_WIDTH-1:0] slice_result,
	input  wire logic                  carry_out,
	input  wire logic                  a_sign,
	input  wire logic                  b_sign,
	output logic      [DATA_WIDTH-1:0] result,
	output logic                       zero,
	output logic                       overflow
);

	logic sub_mode;
	logic b_eff_sign;
	logic sum_sign;
	logic ovf_raw;

	assign sub_mode   = (alu_ctrl == sub_op) || (alu_ctrl == slt_op);
	assign b_eff_sign = b_sign ^ sub_mode;
	assign sum_sign   = slice_result[DATA_WIDTH-1];

	// same operand signs but a different sum sign.
	assign ovf_raw = (a_sign == b_eff_sign) && (sum_sign != a_sign);

	// ==============================
	// result and flags
	// ==============================
	always_comb begin
		result   = slice_result;
		overflow = 1'b0;
		case (alu_ctrl)
			add_op, sub_op: overflow = ovf_raw;
			slt_op: begin
				result   = '0;
				result[0] = sum_sign ^ ovf_raw; // true less-than, even on wrap.
			end
			default: ;
		endcase
	end

	assign zero = (result == '0);

	// with equal msbs the carry out of the chain must match them.
	always_comb begin
		if (alu_ctrl == add_op || sub_mode) begin
			assert final (a_sign != b_eff_sign || carry_out == a_sign)
				else $error("alu_result_unit: carry out inconsistent with operand msbs");
		end
	end

endmodule

`default_nettype wire

// File: hw/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit
	import mips_isa_pkg::*;
	import alu_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  in_valid,
	input  wire logic [31:0]           instr,
	input  wire logic [DATA_WIDTH-1:0] rs_value,
	input  wire logic [DATA_WIDTH-1:0] rt_value,
	output logic                       result_valid,
	output logic      [DATA_WIDTH-1:0] result,
	output logic                       zero,
	output logic                       overflow,
	output logic                       err_illegal_funct,
	output logic                       err_illegal_op
);

	localparam int IMM_WIDTH = IMM_MSB - IMM_LSB + 1;

	alu_op_e               alu_op;
	alu_ctrl_e             alu_ctrl;
	logic                  imm_select;
	logic [DATA_WIDTH-1:0] imm_ext;
	logic [DATA_WIDTH-1:0] operand_b;
	logic [DATA_WIDTH-1:0] slice_result;
	logic [NUM_SLICES:0]   carry;
	logic [DATA_WIDTH-1:0] alu_result;
	logic                  alu_zero;
	logic                  alu_overflow;
	logic                  funct_err;
	logic                  op_err;

	// ==============================
	// decode
	// ==============================
	main_decoder u_main_decoder (
		.opcode     (instr[OPCODE_MSB:OPCODE_LSB]),
		.alu_op     (alu_op),
		.imm_select (imm_select)
	);

	alu_control u_alu_control (
		.alu_op            (alu_op),
		.funct             (instr[FUNCT_MSB:FUNCT_LSB]),
		.alu_ctrl          (alu_ctrl),
		.err_illegal_funct (funct_err),
		.err_illegal_op    (op_err)
	);

	assign imm_ext   = {{(DATA_WIDTH - IMM_WIDTH){instr[IMM_MSB]}}, instr[IMM_MSB:IMM_LSB]};
	assign operand_b = imm_select ? imm_ext : rt_value;

	// ==============================
	// slice chain
	// ==============================
	assign carry[0] = 1'b0; // slice 0 forms its own carry in.

	for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
		alu_slice #(
			.FIRST_SLICE (i == 0)
		) u_alu_slice (
			.alu_ctrl  (alu_ctrl),
			.a         (rs_value[i*SLICE_WIDTH +: SLICE_WIDTH]),
			.b         (operand_b[i*SLICE_WIDTH +: SLICE_WIDTH]),
			.carry_in  (carry[i]),
			.result    (slice_result[i*SLICE_WIDTH +: SLICE_WIDTH]),
			.carry_out (carry[i+1])
		);
	end

	alu_result_unit u_alu_result_unit (
		.alu_ctrl     (alu_ctrl),
		.slice_result (slice_result),
		.carry_out    (carry[NUM_SLICES]),
		.a_sign       (rs_value[DATA_WIDTH-1]),
		.b_sign       (operand_b[DATA_WIDTH-1]),
		.result       (alu_result),
		.zero         (alu_zero),
		.overflow     (alu_overflow)
	);

	// ==============================
	// output register
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_valid      <= 1'b0;
			result            <= '0;
			zero              <= 1'b0;
			overflow          <= 1'b0;
			err_illegal_funct <= 1'b0;
			err_illegal_op    <= 1'b0;
		end else begin
			result_valid <= in_valid;
			if (in_valid) begin
				result            <= alu_result;
				zero              <= alu_zero;
				overflow          <= alu_overflow;
				err_illegal_funct <= funct_err;
				err_illegal_op    <= op_err;
			end
		end
	end

	a_valid_latency: assert property (
		@(posedge clk) disable iff (!rst_n)
		1'b1 |=> (result_valid == $past(in_valid))
	) else $error("execute_unit: result_valid does not follow in_valid by one cycle");

endmodule

`default_nettype wire

// File: test/execute_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit_tb
	import mips_isa_pkg::*;
	import alu_pkg::*;
;

	localparam int     CLK_PERIOD   = 8;
	localparam int     RESET_CYCLES = 4;
	localparam int     N_ARITH_RAND = 50;
	localparam int     N_EXTREME    = 25;
	localparam int     N_MEM        = 20;
	localparam int     N_BEQ        = 20;
	localparam int     N_BAD_FUNCT  = 15;
	localparam int     N_BAD_OP     = 10;
	localparam int     N_INSTR      = N_ARITH_RAND + N_EXTREME + N_MEM + N_BEQ +
		N_BAD_FUNCT + N_BAD_OP;
	localparam int     MAX_CYCLES   = 2 * N_INSTR + 100; // at most one gap per instruction.
	localparam longint MAX_S32      = 64'sd2147483647;
	localparam longint MIN_S32      = -64'sd2147483648;

	localparam logic [5:0] ARITH_FUNCTS [5] = '{funct_add, funct_sub, funct_and, funct_or,
		funct_slt};
	// pairs that overflow on add or sub.
	localparam logic [DATA_WIDTH-1:0] EXT_A [5] = '{32'h7fff_ffff, 32'h8000_0000,
		32'h8000_0000, 32'h7fff_ffff, 32'h8000_0000};
	localparam logic [DATA_WIDTH-1:0] EXT_B [5] = '{32'h0000_0001, 32'hffff_ffff,
		32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};

	typedef struct packed {
		logic [DATA_WIDTH-1:0] result;
		logic                  zero;
		logic                  overflow;
		logic                  err_funct;
		logic                  err_op;
	} expect_t;

	logic                  clk;
	logic                  rst_n;
	logic                  in_valid;
	logic [31:0]           instr;
	logic [DATA_WIDTH-1:0] rs_value;
	logic [DATA_WIDTH-1:0] rt_value;
	logic                  result_valid;
	logic [DATA_WIDTH-1:0] result;
	logic                  zero;
	logic                  overflow;
	logic                  err_illegal_funct;
	logic                  err_illegal_op;

	expect_t               exp_q [$];
	expect_t               cur_exp;
	logic [DATA_WIDTH-1:0] exp_result;
	logic                  exp_zero;
	logic                  exp_overflow;
	logic                  exp_err_funct;
	logic                  exp_err_op;
	int                    seed = 34617;
	int                    errors = 0;
	int                    issued = 0;
	int                    cycle_count = 0;

	execute_unit DUT (
		.clk               (clk),
		.rst_n             (rst_n),
		.in_valid          (in_valid),
		.instr             (instr),
		.rs_value          (rs_value),
		.rt_value          (rt_value),
		.result_valid      (result_valid),
		.result            (result),
		.zero              (zero),
		.overflow          (overflow),
		.err_illegal_funct (err_illegal_funct),
		.err_illegal_op    (err_illegal_op)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ==============================
	// reference model
	// ==============================
	function automatic expect_t add_sub_expect(input logic [DATA_WIDTH-1:0] a,
		input logic [DATA_WIDTH-1:0] b, input bit subtract);
		expect_t e;
		longint  wide;
		e = '0;
		if (subtract)
			wide = longint'($signed(a)) - longint'($signed(b));
		else
			wide = longint'($signed(a)) + longint'($signed(b));
		e.result   = wide[DATA_WIDTH-1:0];
		e.overflow = (wide > MAX_S32) || (wide < MIN_S32); // leaves the signed range.
		return e;
	endfunction

	function automatic expect_t model(input logic [31:0] ins,
		input logic [DATA_WIDTH-1:0] rs, input logic [DATA_WIDTH-1:0] rt);
		expect_t               e;
		logic [DATA_WIDTH-1:0] imm_ext;
		imm_ext = {{(DATA_WIDTH - 16){ins[IMM_MSB]}}, ins[IMM_MSB:IMM_LSB]};
		e = '0;
		case (ins[OPCODE_MSB:OPCODE_LSB])
			op_lw, op_sw: e = add_sub_expect(rs, imm_ext, 1'b0);
			op_beq:       e = add_sub_expect(rs, rt, 1'b1);
			op_r_type: begin
				case (ins[FUNCT_MSB:FUNCT_LSB])
					funct_add:           e = add_sub_expect(rs, rt, 1'b0);
					funct_sub:           e = add_sub_expect(rs, rt, 1'b1);
					funct_or:            e.result = rs | rt;
					funct_and, funct_jr: e.result = rs & rt;
					funct_slt: e.result = {{(DATA_WIDTH - 1){1'b0}}, $signed(rs) < $signed(rt)};
					default: begin
						e.result    = rs & rt;
						e.err_funct = 1'b1;
					end
				endcase
			end
			default: begin
				e.result = rs & rt;
				e.err_op = 1'b1;
			end
		endcase
		e.zero = (e.result == '0);
		return e;
	endfunction

	function automatic bit is_known_funct(input logic [5:0] fn);
		return fn inside {funct_add, funct_sub, funct_and, funct_or, funct_slt, funct_jr};
	endfunction

	function automatic bit is_known_opcode(input logic [5:0] op);
		return op inside {op_r_type, op_beq, op_lw, op_sw};
	endfunction

	function automatic logic [31:0] make_r_type(input logic [5:0] fn);
		return {op_r_type, 5'd1, 5'd2, 5'd3, 5'd0, fn};
	endfunction

	function automatic logic [31:0] make_i_type(input logic [5:0] op, input logic [15:0] imm);
		return {op, 5'd1, 5'd2, imm};
	endfunction

	function automatic logic [31:0] next_word();
		return $random(seed);
	endfunction

	// ==============================
	// stimulus
	// ==============================
	task automatic drive_instr(input logic [31:0] ins, input logic [DATA_WIDTH-1:0] rs,
		input logic [DATA_WIDTH-1:0] rt);
		@(negedge clk);
		in_valid = 1'b1;
		instr    = ins;
		rs_value = rs;
		rt_value = rt;
		exp_q.push_back(model(ins, rs, rt));
		issued++;
	endtask

	task automatic drive_idle();
		@(negedge clk);
		in_valid = 1'b0;
		instr    = next_word(); // junk while idle.
		rs_value = next_word();
		rt_value = next_word();
	endtask

	task automatic maybe_gap();
		if ((next_word() & 32'd3) == 0)
			drive_idle();
	endtask

	task automatic run_arith();
		for (int i = 0; i < N_ARITH_RAND; i++) begin
			drive_instr(make_r_type(ARITH_FUNCTS[i % 5]), next_word(), next_word());
			maybe_gap();
		end
		for (int f = 0; f < 5; f++) begin
			for (int j = 0; j < 5; j++) begin
				drive_instr(make_r_type(ARITH_FUNCTS[f]), EXT_A[j], EXT_B[j]);
				maybe_gap();
			end
		end
	endtask

	task automatic run_mem();
		logic [31:0] word;
		logic [15:0] imm;
		logic [5:0]  op;
		for (int i = 0; i < N_MEM; i++) begin
			word    = next_word();
			imm     = word[15:0];
			imm[15] = i[1]; // negative offsets too.
			if (i >= 16)
				imm[5:0] = 6'h3f; // low bits look like a bad function code.
			op = i[0] ? op_sw : op_lw;
			drive_instr(make_i_type(op, imm), next_word(), next_word());
			maybe_gap();
		end
	endtask

	task automatic run_beq();
		logic [DATA_WIDTH-1:0] rs;
		for (int i = 0; i < N_BEQ; i++) begin
			rs = next_word();
			drive_instr(make_i_type(op_beq, 16'h0010), rs, i[0] ? rs : next_word());
			maybe_gap();
		end
	endtask

	task automatic run_illegal();
		logic [31:0] word;
		for (int i = 0; i < N_BAD_FUNCT - 5; i++) begin
			word = next_word();
			while (is_known_funct(word[5:0]))
				word = next_word();
			drive_instr(make_r_type(word[5:0]), next_word(), next_word());
			maybe_gap();
		end
		for (int i = 0; i < 5; i++) begin
			drive_instr(make_r_type(funct_jr), next_word(), next_word());
			maybe_gap();
		end
		for (int i = 0; i < N_BAD_OP; i++) begin
			word = next_word();
			while (is_known_opcode(word[OPCODE_MSB:OPCODE_LSB]))
				word = next_word();
			drive_instr(word, next_word(), next_word());
			maybe_gap();
		end
	endtask

	// ==============================
	// checking
	// ==============================
	always @(negedge clk) begin
		if (rst_n && result_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("result_valid was high at %0t with no instruction outstanding", $time);
			end else begin
				cur_exp       = exp_q.pop_front();
				exp_result    = cur_exp.result;
				exp_zero      = cur_exp.zero;
				exp_overflow  = cur_exp.overflow;
				exp_err_funct = cur_exp.err_funct;
				exp_err_op    = cur_exp.err_op;
			end
		end
	end

	a_result: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> result == exp_result)
		else begin
			errors++;
			$display("Fail %0t: result %h, expected %h", $time, $sampled(result),
				$sampled(exp_result));
		end

	a_zero: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> zero == exp_zero)
		else begin
			errors++;
			$display("Fail %0t: zero %b, expected %b", $time, $sampled(zero), $sampled(exp_zero));
		end

	a_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> overflow == exp_overflow)
		else begin
			errors++;
			$display("Fail %0t: overflow %b, expected %b", $time, $sampled(overflow),
				$sampled(exp_overflow));
		end

	a_err_funct: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> err_illegal_funct == exp_err_funct)
		else begin
			errors++;
			$display("Fail %0t: err_illegal_funct %b, expected %b", $time,
				$sampled(err_illegal_funct), $sampled(exp_err_funct));
		end

	a_err_op: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> err_illegal_op == exp_err_op)
		else begin
			errors++;
			$display("Fail %0t: err_illegal_op %b, expected %b", $time,
				$sampled(err_illegal_op), $sampled(exp_err_op));
		end

	a_valid_rise: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |=> result_valid)
		else begin
			errors++;
			$display("Fail %0t: result_valid missing one cycle after in_valid", $time);
		end

	a_valid_fall: assert property (@(posedge clk) disable iff (!rst_n)
		!in_valid |=> !result_valid)
		else begin
			errors++;
			$display("Fail %0t: result_valid high without a strobe", $time);
		end

	a_reset_clear: assert property (@(posedge clk)
		!rst_n |-> !result_valid && result == '0 && !zero && !overflow &&
			!err_illegal_funct && !err_illegal_op)
		else begin
			errors++;
			$display("Fail %0t: outputs not cleared during reset", $time);
		end

	// ==============================
	// run control
	// ==============================
	initial begin
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles with %0d results outstanding", cycle_count,
			exp_q.size());
		$display("TB FAILED");
		$finish;
	end

	initial begin
		rst_n    = 1'b1;
		in_valid = 1'b0;
		instr    = '0;
		rs_value = '0;
		rt_value = '0;
		#1;
		rst_n = 1'b0; // falling edge starts the reset.
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		run_arith();
		run_mem();
		run_beq();
		run_illegal();
		drive_idle();

		while (exp_q.size() != 0)
			@(negedge clk);
		@(posedge clk);
		@(negedge clk);

		$display("errors: %0d, instructions issued: %0d", errors, issued);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
hw/mips_isa_pkg.sv
hw/alu_pkg.sv
hw/main_decoder.sv
hw/alu_control.sv
hw/alu_slice.sv
hw/alu_result_unit.sv
hw/execute_unit.sv
test/execute_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the execute unit testbench with Verilator and run it.
# Exit status is zero only when the testbench reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module execute_unit_tb -f src.f \
	&& ./obj_dir/Vexecute_unit_tb | tee /dev/stderr | grep -x "TB PASSED" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
